// File: src/bp_pkg.sv
/*
 * Branch prediction shared definitions
 * Address and counter widths, 2-bit counter state encoding and fetch constants
 * used by the fetch PC unit and the dynamic branch predictor
 */

package bp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int addr_w    = 16;                // Instruction address width
  localparam int counter_w = 2;                 // BHT saturating counter width

  ////////////////////////////////////////////////////////////////////////////
  // Saturating counter states
  ////////////////////////////////////////////////////////////////////////////
  // Upper bit set means predict taken
  localparam logic [counter_w-1:0] strong_nt = 2'd0;  // Strongly not taken
  localparam logic [counter_w-1:0] weak_nt   = 2'd1;  // Weakly not taken
  localparam logic [counter_w-1:0] weak_t    = 2'd2;  // Weakly taken
  localparam logic [counter_w-1:0] strong_t  = 2'd3;  // Strongly taken

  ////////////////////////////////////////////////////////////////////////////
  // Fetch constants
  ////////////////////////////////////////////////////////////////////////////
  localparam logic [addr_w-1:0] reset_pc   = 16'h0000;  // First fetch after reset
  localparam logic [addr_w-1:0] inst_bytes = 16'd2;     // 2-byte instructions

endpackage

// File: src/branch_history_table.sv
/*
 * Branch history table
 * Array of 2-bit saturating counters indexed by PC bits index_w:1,
 * combinational read and synchronous write, write wins over read
 */

`timescale 1ns/10ps

module branch_history_table #(
  parameter int index_w = 3                          // Log2 of the entry count
) (
  input  logic                           clk,        // System clock
  input  logic                           rst,        // Sync reset, active high
  input  logic [bp_pkg::addr_w-1:0]      rd_pc,      // Lookup address (fetch)
  input  logic                           wr_en,      // Counter update strobe
  input  logic [bp_pkg::addr_w-1:0]      wr_pc,      // Address of the resolved branch
  input  logic [bp_pkg::counter_w-1:0]   wr_state,   // New counter value
  output logic [bp_pkg::counter_w-1:0]   rd_state    // Counter at rd_pc
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage and index decode
  ////////////////////////////////////////////////////////////////////////////
  localparam int entries = 2 ** index_w;             // Table depth

  logic [bp_pkg::counter_w-1:0] counters [entries];  // Counter array
  logic [index_w-1:0]           rd_idx;              // Read index
  logic [index_w-1:0]           wr_idx;              // Write index

  // Bit 0 is always zero for 2-byte instructions, so skip it
  assign rd_idx = rd_pc[index_w:1];
  assign wr_idx = wr_pc[index_w:1];

  ////////////////////////////////////////////////////////////////////////////
  // Counter update
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      // Every branch starts out strongly not taken
      for (int i = 0; i < entries; i++) begin
        counters[i] <= bp_pkg::strong_nt;
      end
    end else if (wr_en) begin
      counters[wr_idx] <= wr_state;                  // Lands next cycle
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    if (wr_en) begin
      rd_state = bp_pkg::strong_nt;                  // Table busy, predict not taken
    end else begin
      rd_state = counters[rd_idx];                   // Plain async read
    end
  end

endmodule

// File: src/branch_target_buffer.sv
/*
 * Branch target buffer
 * Direct-mapped entries of valid, full-PC tag and target, with a hit flag;
 * a write in the same cycle turns the lookup into a miss
 */

`timescale 1ns/10ps

module branch_target_buffer #(
  parameter int index_w = 3                          // Log2 of the entry count
) (
  input  logic                       clk,            // System clock
  input  logic                       rst,            // Sync reset, active high
  input  logic [bp_pkg::addr_w-1:0]  rd_pc,          // Lookup address (fetch)
  input  logic                       wr_en,          // Allocate/refresh strobe
  input  logic [bp_pkg::addr_w-1:0]  wr_pc,          // Branch address, stored as tag
  input  logic [bp_pkg::addr_w-1:0]  wr_target,      // Resolved taken target
  output logic [bp_pkg::addr_w-1:0]  rd_target,      // Stored target, zero on miss
  output logic                       hit             // Valid entry with matching tag
);

  localparam int entries = 2 ** index_w;             // Table depth

  ////////////////////////////////////////////////////////////////////////////
  // Entry storage
  ////////////////////////////////////////////////////////////////////////////
  logic [entries-1:0]         valid;                 // Per-entry valid bits
  logic [bp_pkg::addr_w-1:0]  tags    [entries];     // Full PC of the branch
  logic [bp_pkg::addr_w-1:0]  targets [entries];     // Target address
  logic [index_w-1:0]         rd_idx;                // Read index
  logic [index_w-1:0]         wr_idx;                // Write index

  assign rd_idx = rd_pc[index_w:1];
  assign wr_idx = wr_pc[index_w:1];

  // Valid bit set on allocation
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tags[wr_idx]    <= wr_pc;
      targets[wr_idx] <= wr_target;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////
  assign hit       = ~wr_en & valid[rd_idx] & (tags[rd_idx] == rd_pc);  // Write has priority
  assign rd_target = hit ? targets[rd_idx] : '0;    // Zero on miss

endmodule

// File: src/dynamic_branch_predictor.sv
/*
 * Dynamic branch predictor
 * Pairs the BHT and the BTB, looks both up at the fetch PC and updates them
 * from the decode outcome of the instruction held in IF/ID
 */

`timescale 1ns/10ps

module dynamic_branch_predictor #(
  parameter int index_w = 3                                // Log2 of the table depth
) (
  input  logic                           clk,              // System clock
  input  logic                           rst,              // Sync reset, active high
  input  logic [bp_pkg::addr_w-1:0]      fetch_pc,         // Lookup address
  input  logic [bp_pkg::addr_w-1:0]      if_id_pc,         // Address of the resolved branch
  input  logic [bp_pkg::counter_w-1:0]   if_id_prediction, // Counter seen at its fetch
  input  logic                           branch_update,    // Resolved branch, not stalled
  input  logic                           actual_taken,     // Resolved direction
  input  logic [bp_pkg::addr_w-1:0]      actual_target,    // Resolved target
  output logic [bp_pkg::counter_w-1:0]   prediction,       // Counter at fetch_pc
  output logic [bp_pkg::addr_w-1:0]      predicted_target, // BTB target at fetch_pc
  output logic                           btb_hit           // BTB hit at fetch_pc
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal signals
  ////////////////////////////////////////////////////////////////////////////
  logic [bp_pkg::counter_w-1:0] next_state;  // Counter value to write back
  logic                         bht_wr_en;   // BHT write strobe
  logic                         btb_wr_en;   // BTB write strobe

  ////////////////////////////////////////////////////////////////////////////
  // Saturating counter update
  ////////////////////////////////////////////////////////////////////////////
  // Starts from the counter captured at fetch, not a re-read of the table
  always_comb begin
    case (if_id_prediction)
      bp_pkg::strong_nt: next_state = actual_taken ? bp_pkg::weak_nt : bp_pkg::strong_nt;
      bp_pkg::weak_nt:   next_state = actual_taken ? bp_pkg::weak_t  : bp_pkg::strong_nt;
      bp_pkg::weak_t:    next_state = actual_taken ? bp_pkg::strong_t : bp_pkg::weak_nt;
      bp_pkg::strong_t:  next_state = actual_taken ? bp_pkg::strong_t : bp_pkg::weak_t;
      default:           next_state = bp_pkg::strong_nt;
    endcase
  end

  // Every resolved branch trains the BHT, only taken ones allocate a target
  assign bht_wr_en = branch_update;
  assign btb_wr_en = branch_update & actual_taken;

  ////////////////////////////////////////////////////////////////////////////
  // Tables
  ////////////////////////////////////////////////////////////////////////////
  branch_history_table #(
    .index_w  (index_w)
  ) u_bht (
    .clk      (clk),
    .rst      (rst),
    .rd_pc    (fetch_pc),
    .wr_en    (bht_wr_en),
    .wr_pc    (if_id_pc),
    .wr_state (next_state),
    .rd_state (prediction)
  );

  branch_target_buffer #(
    .index_w   (index_w)
  ) u_btb (
    .clk       (clk),
    .rst       (rst),
    .rd_pc     (fetch_pc),
    .wr_en     (btb_wr_en),
    .wr_pc     (if_id_pc),
    .wr_target (actual_target),
    .rd_target (predicted_target),
    .hit       (btb_hit)
  );

endmodule

// File: src/fetch_pc_unit.sv
/*
 * Fetch PC unit
 * Program counter and IF/ID registers, misprediction check on the decode
 * outcome, and next-PC selection between recovery, prediction and sequential
 */

`timescale 1ns/10ps

module fetch_pc_unit (
  input  logic                           clk,              // System clock
  input  logic                           rst,              // Sync reset, active high
  input  logic                           stall,            // Back-pressure from decode
  input  logic                           resolve,          // IF/ID instruction is a branch
  input  logic                           actual_taken,     // Resolved direction
  input  logic [bp_pkg::addr_w-1:0]      actual_target,    // Resolved target
  input  logic [bp_pkg::counter_w-1:0]   prediction,       // Counter at fetch_pc
  input  logic [bp_pkg::addr_w-1:0]      predicted_target, // BTB target at fetch_pc
  input  logic                           btb_hit,          // BTB hit at fetch_pc
  output logic [bp_pkg::addr_w-1:0]      fetch_pc,         // Current fetch address
  output logic [bp_pkg::addr_w-1:0]      if_id_pc,         // IF/ID instruction address
  output logic [bp_pkg::counter_w-1:0]   if_id_prediction, // Counter captured at fetch
  output logic                           if_id_valid,      // IF/ID holds a live instruction
  output logic                           branch_update,    // Train the tables
  output logic                           redirect          // Pulse, fetch was redirected
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal signals
  ////////////////////////////////////////////////////////////////////////////
  logic                      if_id_hit;      // BTB hit at fetch of IF/ID
  logic [bp_pkg::addr_w-1:0] if_id_target;   // Target predicted at fetch of IF/ID
  logic                      fetch_taken;    // Current fetch predicted taken
  logic                      pred_taken;     // IF/ID instruction was predicted taken
  logic                      dir_miss;       // Direction was wrong
  logic                      tgt_miss;       // Taken, but to the wrong place
  logic                      mispredict;     // Recover this cycle
  logic [bp_pkg::addr_w-1:0] seq_pc;         // fetch_pc + 2
  logic [bp_pkg::addr_w-1:0] recover_pc;     // Correct path after a miss
  logic [bp_pkg::addr_w-1:0] next_pc;        // PC for the next cycle

  ////////////////////////////////////////////////////////////////////////////
  // Misprediction check
  ////////////////////////////////////////////////////////////////////////////
  // Stalled or flushed slots never train the tables
  assign branch_update = resolve & if_id_valid & ~stall;

  // Taken needs both a taken counter and a target to go to
  assign pred_taken = if_id_prediction[bp_pkg::counter_w-1] & if_id_hit;
  assign dir_miss   = pred_taken != actual_taken;
  assign tgt_miss   = pred_taken & (if_id_target != actual_target);
  assign mispredict = branch_update & (dir_miss | tgt_miss);

  ////////////////////////////////////////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////////////////////////////////////////
  assign fetch_taken = prediction[bp_pkg::counter_w-1] & btb_hit;
  assign seq_pc      = fetch_pc + bp_pkg::inst_bytes;
  assign recover_pc  = actual_taken ? actual_target : if_id_pc + bp_pkg::inst_bytes;

  always_comb begin
    if (mispredict) begin
      next_pc = recover_pc;                  // Back to the correct path
    end else if (fetch_taken) begin
      next_pc = predicted_target;            // Follow the BTB
    end else begin
      next_pc = seq_pc;                      // Fall through
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // PC and IF/ID registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_pc         <= bp_pkg::reset_pc;
      if_id_pc         <= bp_pkg::reset_pc;
      if_id_prediction <= bp_pkg::strong_nt;
      if_id_hit        <= 1'b0;
      if_id_valid      <= 1'b0;
    end else if (!stall) begin
      fetch_pc         <= next_pc;
      if_id_pc         <= fetch_pc;
      if_id_prediction <= prediction;
      if_id_hit        <= btb_hit;
      if_id_valid      <= ~mispredict;       // Wrong-path fetch is flushed
    end
  end

  // Predicted target moves with the IF/ID stage
  always_ff @(posedge clk) begin
    if (!stall) begin
      if_id_target <= predicted_target;
    end
  end

  // One-cycle pulse, lines up with the redirected fetch_pc
  always_ff @(posedge clk) begin
    if (rst) begin
      redirect <= 1'b0;
    end else begin
      redirect <= mispredict;
    end
  end

endmodule

// File: src/branch_predict_top.sv
/*
 * Branch prediction subsystem top
 * Connects the fetch PC unit to the dynamic branch predictor and sets the
 * table size for both tables
 */

`timescale 1ns/10ps

module branch_predict_top #(
  parameter int index_w = 3                                // Log2 of the table depth
) (
  input  logic                           clk,              // System clock
  input  logic                           rst,              // Sync reset, active high
  input  logic                           stall,            // Back-pressure from decode
  input  logic                           resolve,          // IF/ID instruction is a branch
  input  logic                           actual_taken,     // Resolved direction
  input  logic [bp_pkg::addr_w-1:0]      actual_target,    // Resolved target
  output logic [bp_pkg::addr_w-1:0]      fetch_pc,         // Current fetch address
  output logic [bp_pkg::addr_w-1:0]      if_id_pc,         // IF/ID instruction address
  output logic [bp_pkg::counter_w-1:0]   if_id_prediction, // Counter captured at fetch
  output logic                           if_id_valid,      // IF/ID holds a live instruction
  output logic                           redirect          // Fetch redirect pulse
);

  ////////////////////////////////////////////////////////////////////////////
  // Fetch <-> predictor wires
  ////////////////////////////////////////////////////////////////////////////
  logic [bp_pkg::counter_w-1:0] prediction;        // Counter at fetch_pc
  logic [bp_pkg::addr_w-1:0]    predicted_target;  // BTB target at fetch_pc
  logic                         btb_hit;           // BTB hit at fetch_pc
  logic                         branch_update;     // Gated resolve

  ////////////////////////////////////////////////////////////////////////////
  // Fetch PC unit
  ////////////////////////////////////////////////////////////////////////////
  fetch_pc_unit u_fetch (
    .clk              (clk),
    .rst              (rst),
    .stall            (stall),
    .resolve          (resolve),
    .actual_taken     (actual_taken),
    .actual_target    (actual_target),
    .prediction       (prediction),
    .predicted_target (predicted_target),
    .btb_hit          (btb_hit),
    .fetch_pc         (fetch_pc),
    .if_id_pc         (if_id_pc),
    .if_id_prediction (if_id_prediction),
    .if_id_valid      (if_id_valid),
    .branch_update    (branch_update),
    .redirect         (redirect)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Predictor
  ////////////////////////////////////////////////////////////////////////////
  dynamic_branch_predictor #(
    .index_w          (index_w)
  ) u_dbp (
    .clk              (clk),
    .rst              (rst),
    .fetch_pc         (fetch_pc),
    .if_id_pc         (if_id_pc),
    .if_id_prediction (if_id_prediction),
    .branch_update    (branch_update),
    .actual_taken     (actual_taken),
    .actual_target    (actual_target),
    .prediction       (prediction),
    .predicted_target (predicted_target),
    .btb_hit          (btb_hit)
  );

endmodule

// File: dv/branch_predict_tb.sv
/*
 * Branch prediction subsystem testbench
 * Reference model of the BHT, BTB, PC and IF/ID stage checked against the DUT
 * by concurrent assertions, driven by directed and random resolve traffic
 */

`timescale 1ns/10ps

module branch_predict_tb;

  localparam int index_w = 3;                                  // 8-entry tables
  localparam int entries = 2 ** index_w;
  localparam logic [bp_pkg::addr_w-1:0] br_pc    = 16'h0008;   // Branch under test
  localparam logic [bp_pkg::addr_w-1:0] br_tgt   = 16'h0018;   // Its taken target
  localparam logic [bp_pkg::addr_w-1:0] loop_pc  = 16'h001E;   // Closes the directed loop
  localparam logic [bp_pkg::addr_w-1:0] loop_tgt = 16'h0000;
  localparam logic [bp_pkg::addr_w-1:0] wrap_pc  = 16'h002E;   // Bounds the random stream
  localparam int seek_limit = 64;                              // Cycles per wait loop

  logic                         clk = 1'b0;
  logic                         rst;
  logic                         stall;
  logic                         resolve;
  logic                         actual_taken;
  logic [bp_pkg::addr_w-1:0]    actual_target;
  logic [bp_pkg::addr_w-1:0]    fetch_pc;
  logic [bp_pkg::addr_w-1:0]    if_id_pc;
  logic [bp_pkg::counter_w-1:0] if_id_prediction;
  logic                         if_id_valid;
  logic                         redirect;

  // Reference model state
  logic [bp_pkg::counter_w-1:0] m_bht [entries];               // Counters
  logic [entries-1:0]           m_btb_valid;
  logic [bp_pkg::addr_w-1:0]    m_btb_tag [entries];
  logic [bp_pkg::addr_w-1:0]    m_btb_tgt [entries];
  logic [bp_pkg::addr_w-1:0]    m_fetch_pc;
  logic [bp_pkg::addr_w-1:0]    m_if_pc;
  logic [bp_pkg::counter_w-1:0] m_if_pred;
  logic                         m_if_hit;
  logic [bp_pkg::addr_w-1:0]    m_if_tgt;
  logic                         m_if_valid;
  logic                         m_redirect;

  int err_count    = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  always #2 clk = ~clk;                                        // 4 ns period

  branch_predict_top #(
    .index_w          (index_w)
  ) UUT (
    .clk              (clk),
    .rst              (rst),
    .stall            (stall),
    .resolve          (resolve),
    .actual_taken     (actual_taken),
    .actual_target    (actual_target),
    .fetch_pc         (fetch_pc),
    .if_id_pc         (if_id_pc),
    .if_id_prediction (if_id_prediction),
    .if_id_valid      (if_id_valid),
    .redirect         (redirect)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin : ref_model
    logic                         upd;
    logic [index_w-1:0]           ri;
    logic [index_w-1:0]           wi;
    logic [bp_pkg::counter_w-1:0] rd_ctr;
    logic [bp_pkg::counter_w-1:0] new_ctr;
    logic                         rd_hit;
    logic                         p_taken;
    logic                         miss;
    logic [bp_pkg::addr_w-1:0]    nxt;
    if (rst) begin
      for (int i = 0; i < entries; i++) begin
        m_bht[i] <= bp_pkg::strong_nt;
      end
      m_btb_valid <= '0;
      m_fetch_pc  <= bp_pkg::reset_pc;
      m_if_pc     <= bp_pkg::reset_pc;
      m_if_pred   <= bp_pkg::strong_nt;
      m_if_hit    <= 1'b0;
      m_if_valid  <= 1'b0;
      m_redirect  <= 1'b0;
    end else begin
      upd = resolve && m_if_valid && !stall;                   // Live, unstalled branch
      ri  = m_fetch_pc[index_w:1];
      wi  = m_if_pc[index_w:1];
      // Table being written reads as strong_nt or a miss
      rd_ctr = upd ? bp_pkg::strong_nt : m_bht[ri];
      rd_hit = !(upd && actual_taken) && m_btb_valid[ri] && (m_btb_tag[ri] == m_fetch_pc);
      p_taken = m_if_pred[bp_pkg::counter_w-1] && m_if_hit;
      miss = upd && ((p_taken != actual_taken) || (p_taken && (m_if_tgt != actual_target)));
      if (actual_taken) begin
        new_ctr = (m_if_pred == bp_pkg::strong_t) ? bp_pkg::strong_t : m_if_pred + 2'd1;
      end else begin
        new_ctr = (m_if_pred == bp_pkg::strong_nt) ? bp_pkg::strong_nt : m_if_pred - 2'd1;
      end
      if (miss) begin
        nxt = actual_taken ? actual_target : m_if_pc + bp_pkg::inst_bytes;
      end else if (rd_ctr[bp_pkg::counter_w-1] && rd_hit) begin
        nxt = m_btb_tgt[ri];                                   // Predicted taken
      end else begin
        nxt = m_fetch_pc + bp_pkg::inst_bytes;
      end
      if (upd) begin
        m_bht[wi] <= new_ctr;
      end
      if (upd && actual_taken) begin
        m_btb_valid[wi] <= 1'b1;
        m_btb_tag[wi]   <= m_if_pc;
        m_btb_tgt[wi]   <= actual_target;
      end
      m_redirect <= miss;
      if (!stall) begin
        m_fetch_pc <= nxt;
        m_if_pc    <= m_fetch_pc;
        m_if_pred  <= rd_ctr;
        m_if_hit   <= rd_hit;
        m_if_tgt   <= rd_hit ? m_btb_tgt[ri] : '0;
        m_if_valid <= !miss;                                   // Flush on recovery
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks against the model
  ////////////////////////////////////////////////////////////////////////////
  fetch_pc_matches: assert property (@(posedge clk) disable iff (rst) fetch_pc == m_fetch_pc)
    else flag_error($sformatf("fetch_pc %h, model %h", $sampled(fetch_pc),
                              $sampled(m_fetch_pc)));
  if_id_pc_matches: assert property (@(posedge clk) disable iff (rst) if_id_pc == m_if_pc)
    else flag_error($sformatf("if_id_pc %h, model %h", $sampled(if_id_pc),
                              $sampled(m_if_pc)));
  pred_matches: assert property (@(posedge clk) disable iff (rst) if_id_prediction == m_if_pred)
    else flag_error($sformatf("if_id_prediction %0d, model %0d", $sampled(if_id_prediction),
                              $sampled(m_if_pred)));
  valid_matches: assert property (@(posedge clk) disable iff (rst) if_id_valid == m_if_valid)
    else flag_error($sformatf("if_id_valid %b, model %b", $sampled(if_id_valid),
                              $sampled(m_if_valid)));
  redirect_matches: assert property (@(posedge clk) disable iff (rst) redirect == m_redirect)
    else flag_error($sformatf("redirect %b, model %b", $sampled(redirect),
                              $sampled(m_redirect)));

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic flag_error(input string msg);
    err_count++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic abort_run(input string msg);
    $display("Run aborted at %0t: %s", $time, msg);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic check_eq(input string what, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else flag_error($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic end_test(input string name, input int errs_before);
    int errs;
    errs = err_count - errs_before;
    tests_run++;
    if (errs == 0) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name, errs);
    end
  endtask

  // Called at time 0 or on a falling edge
  task automatic apply_reset();
    rst           = 1'b1;
    stall         = 1'b0;
    resolve       = 1'b0;
    actual_taken  = 1'b0;
    actual_target = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
  endtask

  // Resolves the loop branch taken, everything else unresolved
  task automatic drive_idle();
    stall   = 1'b0;
    resolve = 1'b0;
    if (if_id_valid && if_id_pc == loop_pc) begin
      resolve       = 1'b1;
      actual_taken  = 1'b1;
      actual_target = loop_tgt;
    end
  endtask

  // Waits for pc at fetch or as a live IF/ID instruction
  task automatic seek(input logic [15:0] pc, input bit on_fetch);
    bit found;
    found = 1'b0;
    for (int cyc = 0; cyc < seek_limit && !found; cyc++) begin
      @(negedge clk);
      drive_idle();
      if (on_fetch) found = (fetch_pc == pc);
      else          found = if_id_valid && (if_id_pc == pc);
    end
    if (!found) abort_run($sformatf("PC %h never reached %s", pc, on_fetch ? "fetch" : "IF/ID"));
  endtask

  task automatic resolve_branch(input logic [15:0] pc, input bit taken,
                                input logic [15:0] target, output logic [1:0] seen);
    seek(pc, 1'b0);
    seen          = if_id_prediction;                          // Counter read at its fetch
    resolve       = 1'b1;
    actual_taken  = taken;
    actual_target = target;
  endtask

  function automatic logic [15:0] rand_target();
    return 16'($urandom_range(22) * 2);                        // Even, 0x0000 to 0x002C
  endfunction

  function automatic bit is_branch(input logic [15:0] pc);
    return pc == 16'h0004 || pc == 16'h000A || pc == 16'h0012 || pc == 16'h001A;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    logic [1:0]  seen;
    logic [1:0]  exp_ctr [9];
    logic [15:0] held_pc;
    logic [15:0] held_if_pc;
    logic [1:0]  held_pred;
    logic        held_valid;
    int          errs0;
    void'($urandom(49));
    exp_ctr = '{bp_pkg::strong_nt, bp_pkg::weak_nt, bp_pkg::weak_t, bp_pkg::strong_t,
                bp_pkg::strong_t, bp_pkg::weak_t, bp_pkg::weak_nt, bp_pkg::strong_nt,
                bp_pkg::strong_nt};                            // 4 taken then 5 not taken

    errs0 = err_count;
    apply_reset();
    for (int k = 0; k < 8; k++) begin
      check_eq("fetch_pc", fetch_pc, bp_pkg::reset_pc + bp_pkg::inst_bytes * 16'(k));
      if (k > 0) begin
        check_eq("if_id_pc", if_id_pc, bp_pkg::reset_pc + bp_pkg::inst_bytes * 16'(k - 1));
        check_eq("if_id_valid", 16'(if_id_valid), 16'd1);
      end
      check_eq("if_id_prediction", 16'(if_id_prediction), 16'(bp_pkg::strong_nt));
      @(negedge clk);
    end
    end_test("sequential fetch", errs0);

    errs0 = err_count;
    apply_reset();
    for (int v = 0; v < 9; v++) begin
      resolve_branch(br_pc, v < 4, br_tgt, seen);
      check_eq($sformatf("counter at visit %0d", v), 16'(seen), 16'(exp_ctr[v]));
    end
    end_test("counter saturation", errs0);

    errs0 = err_count;
    apply_reset();
    repeat (2) resolve_branch(br_pc, 1'b1, br_tgt, seen);
    seek(br_pc, 1'b1);
    @(negedge clk);
    check_eq("fetch_pc after predicted branch", fetch_pc, br_tgt);
    check_eq("redirect", 16'(redirect), 16'd0);
    end_test("BTB predicted target", errs0);

    errs0 = err_count;
    resolve_branch(br_pc, 1'b0, br_tgt, seen);                 // weak_t with a BTB hit
    check_eq("counter before recovery", 16'(seen), 16'(bp_pkg::weak_t));
    @(negedge clk);
    resolve = 1'b0;
    check_eq("redirect", 16'(redirect), 16'd1);
    check_eq("fetch_pc after not-taken recovery", fetch_pc, br_pc + bp_pkg::inst_bytes);
    check_eq("if_id_valid", 16'(if_id_valid), 16'd0);
    apply_reset();
    resolve_branch(br_pc, 1'b1, br_tgt, seen);                 // strong_nt, actually taken
    @(negedge clk);
    resolve = 1'b0;
    check_eq("redirect", 16'(redirect), 16'd1);
    check_eq("fetch_pc after taken recovery", fetch_pc, br_tgt);
    check_eq("if_id_valid", 16'(if_id_valid), 16'd0);
    @(negedge clk);
    check_eq("if_id_valid after flush", 16'(if_id_valid), 16'd1);
    check_eq("redirect after pulse", 16'(redirect), 16'd0);
    check_eq("if_id_pc after flush", if_id_pc, br_tgt);
    end_test("misprediction recovery", errs0);

    errs0 = err_count;
    apply_reset();
    seek(br_pc, 1'b0);
    held_pc       = fetch_pc;
    held_if_pc    = if_id_pc;
    held_pred     = if_id_prediction;
    held_valid    = if_id_valid;
    stall         = 1'b1;
    resolve       = 1'b1;                                      // Must be ignored
    actual_taken  = 1'b1;
    actual_target = br_tgt;
    repeat (3) begin
      @(negedge clk);
      check_eq("fetch_pc in stall", fetch_pc, held_pc);
      check_eq("if_id_pc in stall", if_id_pc, held_if_pc);
      check_eq("if_id_prediction in stall", 16'(if_id_prediction), 16'(held_pred));
      check_eq("if_id_valid in stall", 16'(if_id_valid), 16'(held_valid));
      check_eq("redirect in stall", 16'(redirect), 16'd0);
    end
    stall   = 1'b0;
    resolve = 1'b0;
    seek(br_pc, 1'b0);
    check_eq("counter after stalled resolve", 16'(if_id_prediction), 16'(bp_pkg::strong_nt));
    check_eq("fetch_pc after stalled resolve", fetch_pc, br_pc + bp_pkg::inst_bytes);
    end_test("stall", errs0);

    errs0 = err_count;
    apply_reset();
    repeat (400) begin
      @(negedge clk);
      stall   = ($urandom_range(7) == 0);                      // About one cycle in eight
      resolve = 1'b0;
      if (if_id_pc == wrap_pc) begin
        resolve       = 1'b1;
        actual_taken  = 1'b1;
        actual_target = rand_target();
      end else if (is_branch(if_id_pc)) begin
        resolve       = ($urandom_range(3) != 0);
        actual_taken  = $urandom_range(1);
        actual_target = rand_target();
      end
    end
    @(negedge clk);
    stall   = 1'b0;
    resolve = 1'b0;
    @(negedge clk);
    end_test("random stream", errs0);

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
src/bp_pkg.sv
src/branch_history_table.sv
src/branch_target_buffer.sv
src/dynamic_branch_predictor.sv
src/fetch_pc_unit.sv
src/branch_predict_top.sv
dv/branch_predict_tb.sv

// File: Bender.yml
package:
  name: branch_predict

sources:
  # RTL in compile order
  - src/bp_pkg.sv
  - src/branch_history_table.sv
  - src/branch_target_buffer.sv
  - src/dynamic_branch_predictor.sv
  - src/fetch_pc_unit.sv
  - src/branch_predict_top.sv
  # Testbench, top module branch_predict_tb
  - target: test
    files:
      - dv/branch_predict_tb.sv
